// File: design/spike_pkg.sv
package spike_pkg;

	// router dimensions
	localparam int num_neurons = 8;
	localparam int num_dests = 8;
	localparam int fifo_depth = 8;

	// field widths
	localparam int spike_w = 16;
	localparam int id_w = $clog2(num_neurons);
	localparam int tag_w = 4;
	localparam int ptr_w = $clog2(fifo_depth);

	typedef logic [spike_w-1:0] spike_val_t; // raw spike value
	typedef logic [id_w-1:0] neuron_id_t; // source index
	typedef logic [tag_w-1:0] tag_t; // source index, top bit zero
	typedef logic [num_dests-1:0] dest_mask_t; // bit d selects destination d
	typedef logic [ptr_w-1:0] fifo_ptr_t; // wraps at fifo_depth

	// what a neuron offers, 24 bits
	typedef struct packed {
		spike_val_t value;
		dest_mask_t mask;
	} neuron_req_t;

	// what a destination receives, 20 bits
	typedef struct packed {
		tag_t tag;
		spike_val_t value;
	} spike_packet_t;

endpackage

// File: design/spike_arbiter.sv
`timescale 1ns/100ps

module spike_arbiter (
	input logic clk,
	input logic rst,
	input spike_pkg::neuron_req_t neuron_req [spike_pkg::num_neurons],
	input logic [spike_pkg::num_neurons-1:0] neuron_valid,
	output logic [spike_pkg::num_neurons-1:0] neuron_ready,
	input spike_pkg::dest_mask_t dest_full,
	output spike_pkg::spike_packet_t wr_pkt,
	output spike_pkg::dest_mask_t wr_mask
);

	spike_pkg::neuron_id_t rr_ptr; // first neuron looked at this cycle
	spike_pkg::neuron_id_t grant_id; // winner of the scan
	logic grant_found; // some neuron is valid
	spike_pkg::neuron_req_t grant_req; // winner's value and mask
	logic blocked; // winner targets a full buffer
	logic accept; // spike is taken this cycle

	// scan upward from rr_ptr, wrapping past the last neuron
	always_comb begin
		spike_pkg::neuron_id_t scan_id;
		grant_found = 1'b0;
		grant_id = rr_ptr;
		for (int i = 0; i < spike_pkg::num_neurons; i++) begin
			scan_id = rr_ptr + spike_pkg::neuron_id_t'(i); // wraps in 3 bits
			if (!grant_found && neuron_valid[scan_id]) begin
				grant_found = 1'b1;
				grant_id = scan_id;
			end
		end
	end

	assign grant_req = neuron_req[grant_id];

	// a full destination holds back only spikes that target it
	assign blocked = |(grant_req.mask & dest_full);
	assign accept = grant_found && !blocked; // empty mask is accepted too

	always_comb begin
		neuron_ready = '0;
		if (accept) begin
			neuron_ready[grant_id] = 1'b1; // handshake for the winner only
		end
	end

	// one packet, copied into every buffer named in the mask
	always_comb begin
		wr_pkt.tag = {1'b0, grant_id}; // source index as tag
		wr_pkt.value = grant_req.value;
	end

	assign wr_mask = accept ? grant_req.mask : '0;

	// rotation restarts just after the neuron last served
	always_ff @(posedge clk) begin
		if (!rst) begin
			rr_ptr <= '0;
		end else if (accept) begin
			rr_ptr <= spike_pkg::neuron_id_t'(grant_id + 1'b1);
		end
	end

	// the handshake grants at most one neuron per cycle
	a_one_ready: assert property (
		@(posedge clk) disable iff (!rst)
		$onehot0(neuron_ready)
	) else $error("more than one neuron_ready high: %b", neuron_ready);

	// buffers report full, arbiter must never write into them
	a_no_full_write: assert property (
		@(posedge clk) disable iff (!rst)
		(wr_mask & dest_full) == '0
	) else $error("write to full destination, mask %b full %b", wr_mask, dest_full);

endmodule

// File: design/spike_fifo.sv
`timescale 1ns/100ps

module spike_fifo (
	input logic clk,
	input logic rst,
	input spike_pkg::spike_packet_t wr_pkt,
	input logic wr_en,
	output logic full,
	output spike_pkg::spike_packet_t out_pkt,
	output logic out_valid,
	input logic out_ready
);

	localparam int count_w = $clog2(spike_pkg::fifo_depth) + 1; // holds 0 to depth

	spike_pkg::spike_packet_t mem [spike_pkg::fifo_depth]; // payload, no reset
	spike_pkg::fifo_ptr_t wr_ptr;
	spike_pkg::fifo_ptr_t rd_ptr;
	logic [count_w-1:0] count; // entries held
	logic pop;

	assign pop = out_valid && out_ready;

	// flags both follow the count
	assign full = (count == count_w'(spike_pkg::fifo_depth));
	assign out_valid = (count != '0);
	assign out_pkt = mem[rd_ptr]; // oldest entry

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_pkt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle, or write and pop together
			endcase
		end
	end

	// the arbiter must hold off spikes for this buffer while full
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst)
		!(wr_en && full)
	) else $error("write into full buffer");

	// a packet written into an empty buffer shows on the port next cycle
	a_write_visible: assert property (
		@(posedge clk) disable iff (!rst)
		(wr_en && !out_valid) |=> out_valid && out_pkt == $past(wr_pkt)
	) else $error("written packet not at buffer head");

endmodule

// File: design/spike_router.sv
`timescale 1ns/100ps

module spike_router (
	input logic clk,
	input logic rst,
	input spike_pkg::neuron_req_t neuron_req [spike_pkg::num_neurons],
	input logic [spike_pkg::num_neurons-1:0] neuron_valid,
	output logic [spike_pkg::num_neurons-1:0] neuron_ready,
	output spike_pkg::spike_packet_t router_pkt [spike_pkg::num_dests],
	output spike_pkg::dest_mask_t router_valid,
	input spike_pkg::dest_mask_t router_ready
);

	spike_pkg::spike_packet_t wr_pkt; // shared by all buffers
	spike_pkg::dest_mask_t wr_mask; // one write enable per buffer
	spike_pkg::dest_mask_t dest_full; // back to the arbiter

	spike_arbiter arbiter_inst (
		.clk(clk),
		.rst(rst),
		.neuron_req(neuron_req),
		.neuron_valid(neuron_valid),
		.neuron_ready(neuron_ready),
		.dest_full(dest_full),
		.wr_pkt(wr_pkt),
		.wr_mask(wr_mask)
	);

	// one buffer per destination port
	for (genvar d = 0; d < spike_pkg::num_dests; d++) begin : g_dest
		spike_fifo fifo_inst (
			.clk(clk),
			.rst(rst),
			.wr_pkt(wr_pkt),
			.wr_en(wr_mask[d]),
			.full(dest_full[d]),
			.out_pkt(router_pkt[d]),
			.out_valid(router_valid[d]),
			.out_ready(router_ready[d])
		);
	end

	// nothing leaves the router in the cycle after reset
	a_quiet_after_reset: assert property (
		@(posedge clk)
		!rst |=> router_valid == '0
	) else $error("router_valid high right after reset");

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk; // 100 ns period
		end
	end

	// reset held low over the first two rising edges
	initial begin
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

// File: test/spike_router_tb.sv
`timescale 1ns/100ps

module spike_router_tb;

	logic clk;
	logic rst;
	spike_pkg::neuron_req_t neuron_req [spike_pkg::num_neurons];
	logic [spike_pkg::num_neurons-1:0] neuron_valid;
	logic [spike_pkg::num_neurons-1:0] neuron_ready;
	spike_pkg::spike_packet_t router_pkt [spike_pkg::num_dests];
	spike_pkg::dest_mask_t router_valid;
	spike_pkg::dest_mask_t router_ready;

	// records from the data file, one entry each
	string test_name [$];
	int req_test [$];
	int req_neuron [$];
	spike_pkg::neuron_req_t req_data [$];
	int hold_test [$];
	int hold_dest [$];
	int hold_cycles [$];
	int exp_test [$];
	int exp_dest [$];
	spike_pkg::spike_packet_t exp_data [$];

	string cur_test; // name of the running test
	spike_pkg::neuron_req_t req_q [spike_pkg::num_neurons][$]; // front is on the bus
	spike_pkg::spike_packet_t exp_q [spike_pkg::num_dests][$]; // still to arrive
	int hold_left [spike_pkg::num_dests]; // cycles until router_ready rises
	int got_count; // packets seen in this test

	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0; // known once the data is loaded
	bit load_ok;

	tb_clock clock_inst (
		.clk(clk),
		.rst(rst)
	);

	spike_router spike_router_inst (
		.clk(clk),
		.rst(rst),
		.neuron_req(neuron_req),
		.neuron_valid(neuron_valid),
		.neuron_ready(neuron_ready),
		.router_pkt(router_pkt),
		.router_valid(router_valid),
		.router_ready(router_ready)
	);

	function automatic int packets_left();
		int d;
		int total;
		total = 0;
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			total += exp_q[d].size();
		end
		return total;
	endfunction

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: test %s still missing %0d packets after %0d cycles",
				cur_test, packets_left(), cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic load_testdata(output bit ok);
		int fd;
		int rc;
		int a;
		int b;
		int c;
		string tok;
		string rest;
		spike_pkg::neuron_req_t req;
		spike_pkg::spike_packet_t pkt;
		ok = 1'b1;
		fd = $fopen("test/spike_router_testdata.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while (ok && $fscanf(fd, "%s", tok) == 1) begin
				if (tok.getc(0) == "#") begin
					rc = $fgets(rest, fd); // skip the comment text
				end else if (tok == "test") begin
					rc = $fscanf(fd, "%s", tok);
					test_name.push_back(tok);
				end else if (tok == "req") begin
					rc = $fscanf(fd, "%d %h %h", a, b, c);
					if (rc != 3 || a < 0 || a >= spike_pkg::num_neurons) begin
						$display("malformed req record in test data");
						ok = 1'b0;
					end
					req.value = b[15:0];
					req.mask = c[7:0];
					req_test.push_back(test_name.size() - 1);
					req_neuron.push_back(a);
					req_data.push_back(req);
				end else if (tok == "hold") begin
					rc = $fscanf(fd, "%d %d", a, b);
					if (rc != 2 || a < 0 || a >= spike_pkg::num_dests) begin
						$display("malformed hold record in test data");
						ok = 1'b0;
					end
					hold_test.push_back(test_name.size() - 1);
					hold_dest.push_back(a);
					hold_cycles.push_back(b);
				end else if (tok == "exp") begin
					rc = $fscanf(fd, "%d %h %h", a, b, c);
					if (rc != 3 || a < 0 || a >= spike_pkg::num_dests) begin
						$display("malformed exp record in test data");
						ok = 1'b0;
					end
					pkt.tag = b[3:0];
					pkt.value = c[15:0];
					exp_test.push_back(test_name.size() - 1);
					exp_dest.push_back(a);
					exp_data.push_back(pkt);
				end else begin
					$display("unknown record in test data: %s", tok);
					ok = 1'b0;
				end
			end
			$fclose(fd);
			if (test_name.size() == 0) begin
				$display("test data holds no tests");
				ok = 1'b0;
			end
		end
	endtask

	task automatic compare_packet(input string name, input int dest,
			input spike_pkg::spike_packet_t expected,
			input spike_pkg::spike_packet_t actual);
		if (actual !== expected) begin
			$display(
				"mismatch in %s dest %0d: expected tag %h value %h, actual tag %h value %h",
				name, dest, expected.tag, expected.value, actual.tag, actual.value);
			error_count++;
		end
	endtask

	task automatic take_packet(input int d, input spike_pkg::spike_packet_t pkt);
		spike_pkg::spike_packet_t want;
		got_count++;
		if (exp_q[d].size() == 0) begin
			$display("test %s: unexpected packet on destination %0d, tag %h value %h",
				cur_test, d, pkt.tag, pkt.value);
			error_count++;
		end else begin
			want = exp_q[d].pop_front();
			compare_packet(cur_test, d, want, pkt);
		end
	endtask

	// one rising edge, handshakes sampled before the DUT updates
	task automatic step_cycle();
		int n;
		int d;
		@(posedge clk);
		for (n = 0; n < spike_pkg::num_neurons; n++) begin
			if (neuron_valid[n] && neuron_ready[n]) begin
				void'(req_q[n].pop_front());
				if (req_q[n].size() > 0) begin
					neuron_req[n] <= req_q[n][0]; // next spike of this neuron
				end else begin
					neuron_valid[n] <= 1'b0;
				end
			end
		end
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			if (router_valid[d] && router_ready[d]) begin
				take_packet(d, router_pkt[d]);
			end
		end
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			if (hold_left[d] > 0) begin
				hold_left[d]--;
				if (hold_left[d] == 0) begin
					router_ready[d] <= 1'b1;
				end
			end
		end
	endtask

	task automatic run_test(input int t);
		int i;
		int n;
		int d;
		int errs_before;
		errs_before = error_count;
		cur_test = test_name[t];
		got_count = 0;
		for (n = 0; n < spike_pkg::num_neurons; n++) begin
			req_q[n].delete();
		end
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			exp_q[d].delete();
		end
		for (i = 0; i < req_test.size(); i++) begin
			if (req_test[i] == t) begin
				req_q[req_neuron[i]].push_back(req_data[i]);
			end
		end
		for (i = 0; i < exp_test.size(); i++) begin
			if (exp_test[i] == t) begin
				exp_q[exp_dest[i]].push_back(exp_data[i]);
			end
		end
		step_cycle(); // start edge
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			hold_left[d] = 0;
		end
		for (i = 0; i < hold_test.size(); i++) begin
			if (hold_test[i] == t) begin
				hold_left[hold_dest[i]] = hold_cycles[i];
			end
		end
		for (n = 0; n < spike_pkg::num_neurons; n++) begin
			if (req_q[n].size() > 0) begin
				neuron_req[n] <= req_q[n][0];
				neuron_valid[n] <= 1'b1;
			end else begin
				neuron_valid[n] <= 1'b0; // idle in this test
			end
		end
		for (d = 0; d < spike_pkg::num_dests; d++) begin
			router_ready[d] <= (hold_left[d] == 0);
		end
		while (packets_left() > 0) begin
			step_cycle();
		end
		repeat (10) begin
			step_cycle(); // late extras still get caught
		end
		for (n = 0; n < spike_pkg::num_neurons; n++) begin
			if (req_q[n].size() > 0) begin
				$display("test %s: neuron %0d still has %0d requests not accepted",
					cur_test, n, req_q[n].size());
				error_count++;
			end
		end
		if (error_count == errs_before) begin
			$display("test %s: passed, %0d packets", cur_test, got_count);
			pass_count++;
		end else begin
			$display("test %s: failed with %0d errors", cur_test, error_count - errs_before);
			fail_count++;
		end
	endtask

	initial begin
		int n;
		int t;
		for (n = 0; n < spike_pkg::num_neurons; n++) begin
			neuron_req[n] <= '0;
		end
		neuron_valid <= '0;
		router_ready <= '0;
		load_testdata(load_ok);
		if (!load_ok) begin
			$display("cannot read the test data file");
			$display("** FAIL **");
			$finish;
		end else begin
			cycle_limit = 20 * exp_data.size() + 200;
			while (rst !== 1'b1) begin
				@(posedge clk);
			end
			// first cycle out of reset
			if (router_valid !== '0 || neuron_ready !== '0) begin
				$display("router outputs not idle in the first cycle after reset");
				error_count++;
			end
			for (t = 0; t < test_name.size(); t++) begin
				run_test(t);
			end
			$display("tests %0d, passed %0d, failed %0d, errors %0d",
				test_name.size(), pass_count, fail_count, error_count);
			if (fail_count == 0 && error_count == 0) begin
				$display("** PASS **");
			end else begin
				$display("** FAIL **");
			end
			$finish;
		end
	end

endmodule

// File: test/spike_router_testdata.txt
# test <name>                    starts a test, records below belong to it
# req <neuron> <value> <mask>    spikes per neuron in send order, value and mask in hex
# hold <dest> <cycles>           router_ready low this many cycles, decimal
# exp <dest> <tag> <value>       packets per destination in arrival order, hex
test single
req 2 1234 01
exp 0 2 1234
# pointer now 3
test multicast
req 5 abcd 96
exp 1 5 abcd
exp 2 5 abcd
exp 4 5 abcd
exp 7 5 abcd
# pointer now 6, so the scan starts at neuron 6
test round_robin
req 0 3000 08
req 1 3001 08
req 2 3002 08
req 3 3003 08
req 4 3004 08
req 5 3005 08
req 6 3006 08
req 7 3007 08
exp 3 6 3006
exp 3 7 3007
exp 3 0 3000
exp 3 1 3001
exp 3 2 3002
exp 3 3 3003
exp 3 4 3004
exp 3 5 3005
# ten spikes for destination 5 while it is held, neuron 2 keeps going to 6
test backpressure
hold 5 30
req 0 5001 20
req 0 5002 20
req 0 5003 20
req 0 5004 20
req 0 5005 20
req 1 5101 20
req 1 5102 20
req 1 5103 20
req 1 5104 20
req 1 5105 20
req 2 6201 40
req 2 6202 40
req 2 6203 40
exp 5 0 5001
exp 5 1 5101
exp 5 0 5002
exp 5 1 5102
exp 5 0 5003
exp 5 1 5103
exp 5 0 5004
exp 5 1 5104
exp 5 0 5005
exp 5 1 5105
exp 6 2 6201
exp 6 2 6202
exp 6 2 6203
# pointer now 2, the empty mask moves it past neuron 4
test empty_mask
req 4 dead 00
req 4 4444 01
req 5 5555 01
exp 0 5 5555
exp 0 4 4444

// File: verilog.f
design/spike_pkg.sv
design/spike_arbiter.sv
design/spike_fifo.sv
design/spike_router.sv
test/tb_clock.sv
test/spike_router_tb.sv

// File: Makefile
TOP := spike_router_tb
BIN := obj_dir/V$(TOP)
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
